//--- common/demux_settings.svh
// read demux sizes
`ifndef DEMUX_SETTINGS_SVH
`define DEMUX_SETTINGS_SVH

// --------------------------------------------------
// port counts
// --------------------------------------------------

// master ports behind the demux
`define NUM_PORTS 4

// --------------------------------------------------
// id tracking
// --------------------------------------------------

// axi id width, one in-flight slot per id value
`define ID_BITS 3

// in-flight counter width
// a slot counts as full at the all-ones value
`define CNT_BITS 3

// --------------------------------------------------
// payload widths
// --------------------------------------------------

// read address width
`define ADDR_BITS 32

// read data width
`define DATA_BITS 32

`endif

//--- common/demux_pkg.sv
// read demux types
`default_nettype none

`include "demux_settings.svh"

package demux_pkg;

  // --------------------------------------------------
  // vector types
  // --------------------------------------------------

  // index of a master port
  typedef logic [$clog2(`NUM_PORTS)-1:0] port_sel_t;

  // full axi id, also used as the slot lookup key
  typedef logic [`ID_BITS-1:0] axi_id_t;

  // ar address and r data
  typedef logic [`ADDR_BITS-1:0] addr_t;
  typedef logic [`DATA_BITS-1:0] data_t;

  // bursts in flight for one id
  typedef logic [`CNT_BITS-1:0] flight_cnt_t;

  // --------------------------------------------------
  // ar route control states
  // --------------------------------------------------

  // open   : admission rule is evaluated each cycle
  // locked : ar already presented, waiting for the port ready
  typedef enum logic [0:0] {
    ROUTE_OPEN   = 1'b0,
    ROUTE_LOCKED = 1'b1
  } route_state_e;

endpackage

`default_nettype wire

//--- ar_route/id_flight_slot.sv
// per-id in-flight slot
`timescale 1ns/10ps
`default_nettype none

module id_flight_slot (
  input  wire                  clk_i,
  input  wire                  rst_n_i,
  // already qualified for this id
  input  wire                  push_i,
  input  wire                  pop_i,
  input  demux_pkg::port_sel_t push_sel_i,
  // status back to the route control
  output logic                 occupied_o,
  output logic                 full_o,
  output demux_pkg::port_sel_t target_o
);

  demux_pkg::flight_cnt_t cnt_q;
  demux_pkg::port_sel_t   target_q;

  // --------------------------------------------------
  // burst counter
  // --------------------------------------------------

  // push and pop together cancel out
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      cnt_q <= '0;
    end else begin
      case ({push_i, pop_i})
        2'b10:   cnt_q <= cnt_q + demux_pkg::flight_cnt_t'(1);
        2'b01:   cnt_q <= cnt_q - demux_pkg::flight_cnt_t'(1);
        default: cnt_q <= cnt_q;
      endcase
    end
  end

  // --------------------------------------------------
  // target port
  // --------------------------------------------------

  // port of the bursts in flight, loaded on every push
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      target_q <= '0;
    end else if (push_i) begin
      target_q <= push_sel_i;
    end
  end

  assign occupied_o = |cnt_q;
  // all ones is the last value the counter can hold
  assign full_o     = &cnt_q;
  assign target_o   = target_q;

endmodule

`default_nettype wire

//--- ar_route/ar_route_ctrl.sv
// ar admission and steering
`timescale 1ns/10ps
`default_nettype none

`include "demux_settings.svh"

module ar_route_ctrl (
  input  wire                                        clk_i,
  input  wire                                        rst_n_i,
  // slave ar
  input  wire                                        s_ar_valid_i,
  input  demux_pkg::axi_id_t                         s_ar_id_i,
  input  demux_pkg::addr_t                           s_ar_addr_i,
  input  demux_pkg::port_sel_t                       s_ar_sel_i,
  output logic                                       s_ar_ready_o,
  // master ar
  output logic [`NUM_PORTS-1:0]                      m_ar_valid_o,
  input  wire  [`NUM_PORTS-1:0]                      m_ar_ready_i,
  output demux_pkg::axi_id_t                         m_ar_id_o,
  output demux_pkg::addr_t                           m_ar_addr_o,
  // slot status, indexed by id
  input  wire  [(1 << `ID_BITS)-1:0]                 slot_occupied_i,
  input  wire  [(1 << `ID_BITS)-1:0]                 slot_full_i,
  input  demux_pkg::port_sel_t [(1 << `ID_BITS)-1:0] slot_target_i,
  // push towards the slots
  output logic                                       push_o,
  output demux_pkg::axi_id_t                         push_id_o,
  output demux_pkg::port_sel_t                       push_sel_o
);

  demux_pkg::route_state_e state_q;
  demux_pkg::route_state_e state_d;

  // lookup of the incoming id
  logic                 lookup_occupied;
  demux_pkg::port_sel_t lookup_target;
  logic                 any_full;
  logic                 admit;

  // internal ar handshake towards the selected port
  logic                 ar_valid;
  logic                 sel_ready;

  // --------------------------------------------------
  // id lookup and admission rule
  // --------------------------------------------------
  assign lookup_occupied = slot_occupied_i[s_ar_id_i];
  assign lookup_target   = slot_target_i[s_ar_id_i];

  // one full counter stalls every id
  assign any_full = |slot_full_i;

  // free id, or same port as the bursts already in flight
  assign admit = s_ar_valid_i & ~any_full &
                 (~lookup_occupied | (lookup_target == s_ar_sel_i));

  // ready of the port the beat is aimed at
  assign sel_ready = m_ar_ready_i[s_ar_sel_i];

  // --------------------------------------------------
  // handshake control
  // --------------------------------------------------
  always_comb begin
    ar_valid     = 1'b0;
    s_ar_ready_o = 1'b0;
    push_o       = 1'b0;
    state_d      = state_q;
    case (state_q)
      demux_pkg::ROUTE_OPEN: begin
        if (admit) begin
          ar_valid = 1'b1;
          if (sel_ready) begin
            // accepted in the same cycle
            s_ar_ready_o = 1'b1;
            push_o       = 1'b1;
          end else begin
            // keep the valid up no matter what the slots do next
            state_d = demux_pkg::ROUTE_LOCKED;
          end
        end
      end
      demux_pkg::ROUTE_LOCKED: begin
        // admission already granted, only the port ready matters
        ar_valid = 1'b1;
        if (sel_ready) begin
          s_ar_ready_o = 1'b1;
          push_o       = 1'b1;
          state_d      = demux_pkg::ROUTE_OPEN;
        end
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= demux_pkg::ROUTE_OPEN;
    end else begin
      state_q <= state_d;
    end
  end

  // --------------------------------------------------
  // steering
  // --------------------------------------------------

  // only the selected port sees a valid
  always_comb begin
    for (int i = 0; i < `NUM_PORTS; i++) begin
      m_ar_valid_o[i] = ar_valid & (s_ar_sel_i == demux_pkg::port_sel_t'(i));
    end
  end

  // payload broadcast to all ports
  assign m_ar_id_o   = s_ar_id_i;
  assign m_ar_addr_o = s_ar_addr_i;

  // slot entry for the accepted beat
  assign push_id_o  = s_ar_id_i;
  assign push_sel_o = s_ar_sel_i;

endmodule

`default_nettype wire

//--- verilog/r_rr_mux.sv
// r round-robin merge
`timescale 1ns/10ps
`default_nettype none

`include "demux_settings.svh"

module r_rr_mux (
  input  wire                                 clk_i,
  input  wire                                 rst_n_i,
  // master r
  input  wire  [`NUM_PORTS-1:0]               m_r_valid_i,
  input  demux_pkg::axi_id_t [`NUM_PORTS-1:0] m_r_id_i,
  input  demux_pkg::data_t [`NUM_PORTS-1:0]   m_r_data_i,
  input  wire  [`NUM_PORTS-1:0]               m_r_last_i,
  output logic [`NUM_PORTS-1:0]               m_r_ready_o,
  // slave r
  output logic                                s_r_valid_o,
  output demux_pkg::axi_id_t                  s_r_id_o,
  output demux_pkg::data_t                    s_r_data_o,
  output logic                                s_r_last_o,
  input  wire                                 s_r_ready_i
);

  // port after the last granted one
  demux_pkg::port_sel_t rr_ptr_q;

  // lock while a granted beat is stalled
  logic                 lock_q;
  demux_pkg::port_sel_t lock_idx_q;

  // round-robin pick
  logic                 pick_valid;
  demux_pkg::port_sel_t pick_idx;

  // port currently driving the slave side
  demux_pkg::port_sel_t gnt_idx;
  logic                 xfer;

  // --------------------------------------------------
  // round-robin search
  // --------------------------------------------------

  // first requester at or after the pointer, wrapping around
  always_comb begin : pick_proc
    demux_pkg::port_sel_t cand;
    pick_valid = 1'b0;
    pick_idx   = rr_ptr_q;
    for (int k = 0; k < `NUM_PORTS; k++) begin
      cand = demux_pkg::port_sel_t'((int'(rr_ptr_q) + k) % `NUM_PORTS);
      if (!pick_valid && m_r_valid_i[cand]) begin
        pick_valid = 1'b1;
        pick_idx   = cand;
      end
    end
  end

  // stalled beat keeps its grant
  assign gnt_idx = lock_q ? lock_idx_q : pick_idx;

  // --------------------------------------------------
  // slave side
  // --------------------------------------------------

  // with no requester the pick rests on a port whose valid is low
  assign s_r_valid_o = m_r_valid_i[gnt_idx];
  assign s_r_id_o    = m_r_id_i[gnt_idx];
  assign s_r_data_o  = m_r_data_i[gnt_idx];
  assign s_r_last_o  = m_r_last_i[gnt_idx];

  assign xfer = s_r_valid_o & s_r_ready_i;

  // grant back only to the winning port
  always_comb begin
    for (int i = 0; i < `NUM_PORTS; i++) begin
      m_r_ready_o[i] = xfer & (gnt_idx == demux_pkg::port_sel_t'(i));
    end
  end

  // --------------------------------------------------
  // pointer and lock
  // --------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rr_ptr_q   <= '0;
      lock_q     <= 1'b0;
      lock_idx_q <= '0;
    end else begin
      if (xfer) begin
        // priority moves past the port just served
        rr_ptr_q <= demux_pkg::port_sel_t'((int'(gnt_idx) + 1) % `NUM_PORTS);
        lock_q   <= 1'b0;
      end else if (s_r_valid_o) begin
        // stalled, hold this port until the slave takes it
        lock_q     <= 1'b1;
        lock_idx_q <= gnt_idx;
      end
    end
  end

endmodule

`default_nettype wire

//--- verilog/axi_rd_demux.sv
// axi read demux top
`timescale 1ns/10ps
`default_nettype none

`include "demux_settings.svh"

module axi_rd_demux (
  input  wire                                      clk_i,
  input  wire                                      rst_n_i,
  // slave ar
  input  wire                                      s_ar_valid_i,
  input  demux_pkg::axi_id_t                       s_ar_id_i,
  input  demux_pkg::addr_t                         s_ar_addr_i,
  input  demux_pkg::port_sel_t                     s_ar_sel_i,
  output logic                                     s_ar_ready_o,
  // master ar
  output logic [`NUM_PORTS-1:0]                    m_ar_valid_o,
  input  wire  [`NUM_PORTS-1:0]                    m_ar_ready_i,
  output demux_pkg::axi_id_t                       m_ar_id_o,
  output demux_pkg::addr_t                         m_ar_addr_o,
  // master r
  input  wire  [`NUM_PORTS-1:0]                    m_r_valid_i,
  input  demux_pkg::axi_id_t [`NUM_PORTS-1:0]      m_r_id_i,
  input  demux_pkg::data_t [`NUM_PORTS-1:0]        m_r_data_i,
  input  wire  [`NUM_PORTS-1:0]                    m_r_last_i,
  output logic [`NUM_PORTS-1:0]                    m_r_ready_o,
  // slave r
  output logic                                     s_r_valid_o,
  output demux_pkg::axi_id_t                       s_r_id_o,
  output demux_pkg::data_t                         s_r_data_o,
  output logic                                     s_r_last_o,
  input  wire                                      s_r_ready_i
);

  // one slot per id value
  localparam int unsigned NUM_IDS = 1 << `ID_BITS;

  // push from the ar side
  logic                                     push;
  demux_pkg::axi_id_t                       push_id;
  demux_pkg::port_sel_t                     push_sel;

  // pop on the handshake of a last r beat
  logic                                     pop;

  // slot bus
  logic [NUM_IDS-1:0]                       slot_push;
  logic [NUM_IDS-1:0]                       slot_pop;
  logic [NUM_IDS-1:0]                       slot_occupied;
  logic [NUM_IDS-1:0]                       slot_full;
  demux_pkg::port_sel_t [NUM_IDS-1:0]       slot_target;

  // --------------------------------------------------
  // ar admission and steering
  // --------------------------------------------------
  ar_route_ctrl u_ar_route_ctrl (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .s_ar_valid_i    (s_ar_valid_i),
    .s_ar_id_i       (s_ar_id_i),
    .s_ar_addr_i     (s_ar_addr_i),
    .s_ar_sel_i      (s_ar_sel_i),
    .s_ar_ready_o    (s_ar_ready_o),
    .m_ar_valid_o    (m_ar_valid_o),
    .m_ar_ready_i    (m_ar_ready_i),
    .m_ar_id_o       (m_ar_id_o),
    .m_ar_addr_o     (m_ar_addr_o),
    .slot_occupied_i (slot_occupied),
    .slot_full_i     (slot_full),
    .slot_target_i   (slot_target),
    .push_o          (push),
    .push_id_o       (push_id),
    .push_sel_o      (push_sel)
  );

  // --------------------------------------------------
  // in-flight slots
  // --------------------------------------------------

  // burst retires when its last beat leaves on the slave side
  assign pop = s_r_valid_o & s_r_ready_i & s_r_last_o;

  for (genvar g = 0; g < NUM_IDS; g++) begin : gen_slot
    // one-hot qualify push and pop for this id
    assign slot_push[g] = push & (push_id == demux_pkg::axi_id_t'(g));
    assign slot_pop[g]  = pop & (s_r_id_o == demux_pkg::axi_id_t'(g));

    id_flight_slot u_slot (
      .clk_i      (clk_i),
      .rst_n_i    (rst_n_i),
      .push_i     (slot_push[g]),
      .pop_i      (slot_pop[g]),
      .push_sel_i (push_sel),
      .occupied_o (slot_occupied[g]),
      .full_o     (slot_full[g]),
      .target_o   (slot_target[g])
    );
  end

  // --------------------------------------------------
  // r merge
  // --------------------------------------------------
  r_rr_mux u_r_rr_mux (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .m_r_valid_i (m_r_valid_i),
    .m_r_id_i    (m_r_id_i),
    .m_r_data_i  (m_r_data_i),
    .m_r_last_i  (m_r_last_i),
    .m_r_ready_o (m_r_ready_o),
    .s_r_valid_o (s_r_valid_o),
    .s_r_id_o    (s_r_id_o),
    .s_r_data_o  (s_r_data_o),
    .s_r_last_o  (s_r_last_o),
    .s_r_ready_i (s_r_ready_i)
  );

endmodule

`default_nettype wire

//--- testbench/axi_rd_demux_sva.sv
// read demux handshake assertions
`timescale 1ns/10ps
`default_nettype none

`include "demux_settings.svh"

module axi_rd_demux_sva (
  input  wire                  clk_i,
  input  wire                  rst_n_i,
  // slave ar side
  input  wire                  req_valid_i,
  // master ar side
  input  wire [`NUM_PORTS-1:0] ar_valid_i,
  input  wire [`NUM_PORTS-1:0] ar_ready_i,
  input  demux_pkg::axi_id_t   ar_id_i,
  input  demux_pkg::addr_t     ar_addr_i,
  // slave r side
  input  wire                  r_valid_i,
  input  wire                  r_ready_i,
  input  demux_pkg::axi_id_t   r_id_i,
  input  demux_pkg::data_t     r_data_i,
  input  wire                  r_last_i
);

  // --------------------------------------------------
  // master ar
  // --------------------------------------------------

  // never steered to two ports at once, and never without a slave ar behind it
  ar_onehot_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $onehot0(ar_valid_i) && (!(|ar_valid_i) || req_valid_i))
    else $error("master ar valid on more than one port or without a slave ar");

  // waiting beat stays on the same port with the same payload
  ar_hold_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (|(ar_valid_i & ~ar_ready_i)) |=>
      (ar_valid_i == $past(ar_valid_i)) && $stable(ar_id_i) && $stable(ar_addr_i))
    else $error("master ar valid or payload changed before ready");

  // --------------------------------------------------
  // slave r
  // --------------------------------------------------
  r_hold_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (r_valid_i && !r_ready_i) |=>
      r_valid_i && $stable(r_id_i) && $stable(r_data_i) && $stable(r_last_i))
    else $error("slave r valid or payload changed before ready");

endmodule

`default_nettype wire

//--- testbench/tb_axi_rd_demux.sv
// read demux testbench
`timescale 1ns/10ps
`default_nettype none

`include "demux_settings.svh"

module tb_axi_rd_demux;

  localparam int NUM_ARS = 300;
  localparam int NUM_IDS = 1 << `ID_BITS;
  localparam int CNT_MAX = (1 << `CNT_BITS) - 1;
  // 64 cycles per ar covers 4 beats at the slowest slave ready rate
  localparam int MAX_CYCLES = NUM_ARS * 64 + 800;

  typedef logic [`NUM_PORTS-1:0] port_mask_t;

  logic                                 clk_i;
  logic                                 rst_n_i;
  logic                                 s_ar_valid_i;
  demux_pkg::axi_id_t                   s_ar_id_i;
  demux_pkg::addr_t                     s_ar_addr_i;
  demux_pkg::port_sel_t                 s_ar_sel_i;
  logic                                 s_ar_ready_o;
  port_mask_t                           m_ar_valid_o;
  port_mask_t                           m_ar_ready_i;
  demux_pkg::axi_id_t                   m_ar_id_o;
  demux_pkg::addr_t                     m_ar_addr_o;
  port_mask_t                           m_r_valid_i;
  demux_pkg::axi_id_t [`NUM_PORTS-1:0]  m_r_id_i;
  demux_pkg::data_t [`NUM_PORTS-1:0]    m_r_data_i;
  port_mask_t                           m_r_last_i;
  port_mask_t                           m_r_ready_o;
  logic                                 s_r_valid_o;
  demux_pkg::axi_id_t                   s_r_id_o;
  demux_pkg::data_t                     s_r_data_o;
  logic                                 s_r_last_o;
  logic                                 s_r_ready_i;

  // random source
  logic [15:0]          lfsr_q;

  // model of the id slots and ar control
  int                   id_cnt [NUM_IDS];
  demux_pkg::port_sel_t id_tgt [NUM_IDS];
  logic                 ar_pending;
  logic                 ar_locked;
  int                   ar_sent;

  // model of the r arbiter
  demux_pkg::port_sel_t rr_ptr;
  logic                 r_lock;
  demux_pkg::port_sel_t r_lock_idx;

  // responder beats per port, head is the one on the bus
  demux_pkg::data_t     beat_data_q [`NUM_PORTS][$];
  demux_pkg::axi_id_t   beat_id_q [`NUM_PORTS][$];
  logic                 beat_last_q [`NUM_PORTS][$];
  port_mask_t           r_hold;

  int                   cycles;
  logic                 run_done;

  axi_rd_demux uut (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .s_ar_valid_i (s_ar_valid_i),
    .s_ar_id_i    (s_ar_id_i),
    .s_ar_addr_i  (s_ar_addr_i),
    .s_ar_sel_i   (s_ar_sel_i),
    .s_ar_ready_o (s_ar_ready_o),
    .m_ar_valid_o (m_ar_valid_o),
    .m_ar_ready_i (m_ar_ready_i),
    .m_ar_id_o    (m_ar_id_o),
    .m_ar_addr_o  (m_ar_addr_o),
    .m_r_valid_i  (m_r_valid_i),
    .m_r_id_i     (m_r_id_i),
    .m_r_data_i   (m_r_data_i),
    .m_r_last_i   (m_r_last_i),
    .m_r_ready_o  (m_r_ready_o),
    .s_r_valid_o  (s_r_valid_o),
    .s_r_id_o     (s_r_id_o),
    .s_r_data_o   (s_r_data_o),
    .s_r_last_o   (s_r_last_o),
    .s_r_ready_i  (s_r_ready_i)
  );

  bind axi_rd_demux axi_rd_demux_sva u_sva (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .req_valid_i (s_ar_valid_i),
    .ar_valid_i  (m_ar_valid_o),
    .ar_ready_i  (m_ar_ready_i),
    .ar_id_i     (m_ar_id_o),
    .ar_addr_i   (m_ar_addr_o),
    .r_valid_i   (s_r_valid_o),
    .r_ready_i   (s_r_ready_i),
    .r_id_i      (s_r_id_o),
    .r_data_i    (s_r_data_o),
    .r_last_i    (s_r_last_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  // --------------------------------------------------
  // helpers
  // --------------------------------------------------

  // 16-bit fibonacci lfsr, taps 16 14 13 11, one step per bit
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] val;
    logic        fb;
    val = '0;
    for (int i = 0; i < n; i++) begin
      fb     = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
      lfsr_q = {lfsr_q[14:0], fb};
      val    = {val[30:0], fb};
    end
    return val;
  endfunction

  function automatic port_mask_t port_bit(input demux_pkg::port_sel_t p);
    return port_mask_t'(1) << p;
  endfunction

  function automatic demux_pkg::port_sel_t port_index(input port_mask_t mask);
    demux_pkg::port_sel_t idx;
    idx = '0;
    for (int i = 0; i < `NUM_PORTS; i++) begin
      if (mask[i]) begin
        idx = demux_pkg::port_sel_t'(i);
      end
    end
    return idx;
  endfunction

  task automatic fail_run();
    $display("Checks failed");
    $fatal(1);
  endtask

  task automatic check_sel(input string what, input demux_pkg::port_sel_t exp,
                           input demux_pkg::port_sel_t got);
    if (got !== exp) begin
      $display("Error at %0t: %s expected %0d got %0d", $time, what, exp, got);
      fail_run();
    end
  endtask

  task automatic check_id(input string what, input demux_pkg::axi_id_t exp,
                          input demux_pkg::axi_id_t got);
    if (got !== exp) begin
      $display("Error at %0t: %s expected %0d got %0d", $time, what, exp, got);
      fail_run();
    end
  endtask

  task automatic check_addr(input string what, input demux_pkg::addr_t exp,
                            input demux_pkg::addr_t got);
    if (got !== exp) begin
      $display("Error at %0t: %s expected %h got %h", $time, what, exp, got);
      fail_run();
    end
  endtask

  task automatic check_data(input string what, input demux_pkg::data_t exp,
                            input demux_pkg::data_t got);
    if (got !== exp) begin
      $display("Error at %0t: %s expected %h got %h", $time, what, exp, got);
      fail_run();
    end
  endtask

  task automatic check_mask(input string what, input port_mask_t exp, input port_mask_t got);
    if (got !== exp) begin
      $display("Error at %0t: %s expected %b got %b", $time, what, exp, got);
      fail_run();
    end
  endtask

  task automatic check_bit(input string what, input logic exp, input logic got);
    if (got !== exp) begin
      $display("Error at %0t: %s expected %b got %b", $time, what, exp, got);
      fail_run();
    end
  endtask

  task automatic check_idle_outputs();
    check_bit("slave ar ready at reset", 1'b0, s_ar_ready_o);
    check_mask("master ar valid at reset", '0, m_ar_valid_o);
    check_mask("master r ready at reset", '0, m_r_ready_o);
    check_bit("slave r valid at reset", 1'b0, s_r_valid_o);
  endtask

  // responder answers an accepted ar with 1 to 4 beats
  // data holds port, id, beat index and ar number
  task automatic queue_burst(input demux_pkg::port_sel_t p, input demux_pkg::axi_id_t id);
    int len;
    len = int'(take_bits(2)) + 1;
    for (int b = 0; b < len; b++) begin
      beat_data_q[p].push_back(demux_pkg::data_t'({8'(p), 8'(id), 8'(b), 8'(ar_sent)}));
      beat_id_q[p].push_back(id);
      beat_last_q[p].push_back(b == len - 1);
    end
  endtask

  // --------------------------------------------------
  // checks, run mid-cycle on settled values
  // --------------------------------------------------

  // admission: free id or same port, and no id at the full count
  task automatic check_ar_side();
    port_mask_t           exp_valid;
    logic                 exp_ready;
    logic                 any_full;
    demux_pkg::axi_id_t   id;
    demux_pkg::port_sel_t sel;
    id       = s_ar_id_i;
    sel      = s_ar_sel_i;
    any_full = 1'b0;
    for (int i = 0; i < NUM_IDS; i++) begin
      if (id_cnt[i] == CNT_MAX) begin
        any_full = 1'b1;
      end
    end
    exp_valid = '0;
    if (ar_locked) begin
      exp_valid = port_bit(sel);
    end else if (s_ar_valid_i && !any_full && (id_cnt[id] == 0 || id_tgt[id] == sel)) begin
      exp_valid = port_bit(sel);
    end
    exp_ready = exp_valid[sel] & m_ar_ready_i[sel];
    check_mask("master ar valid", exp_valid, m_ar_valid_o);
    check_bit("slave ar ready", exp_ready, s_ar_ready_o);
    if (exp_ready) begin
      check_sel("ar transfer port", sel, port_index(m_ar_valid_o & m_ar_ready_i));
      check_id("master ar id", id, m_ar_id_o);
      check_addr("master ar addr", s_ar_addr_i, m_ar_addr_o);
      id_cnt[id]++;
      id_tgt[id] = sel;
      queue_burst(sel, id);
      ar_pending = 1'b0;
    end
    // presented but not taken, held until the port is ready
    ar_locked = (|exp_valid) & ~exp_ready;
  endtask

  // round robin from the pointer, locked onto a stalled beat
  task automatic check_r_side();
    demux_pkg::port_sel_t gnt;
    demux_pkg::port_sel_t cand;
    logic                 exp_valid;
    logic                 xfer;
    gnt       = rr_ptr;
    exp_valid = 1'b0;
    if (r_lock) begin
      gnt       = r_lock_idx;
      exp_valid = m_r_valid_i[gnt];
    end else begin
      for (int k = 0; k < `NUM_PORTS; k++) begin
        cand = demux_pkg::port_sel_t'((int'(rr_ptr) + k) % `NUM_PORTS);
        if (!exp_valid && m_r_valid_i[cand]) begin
          exp_valid = 1'b1;
          gnt       = cand;
        end
      end
    end
    xfer = exp_valid & s_r_ready_i;
    check_bit("slave r valid", exp_valid, s_r_valid_o);
    check_mask("master r ready", xfer ? port_bit(gnt) : port_mask_t'(0), m_r_ready_o);
    if (exp_valid) begin
      check_id("slave r id", beat_id_q[gnt][0], s_r_id_o);
      check_data("slave r data", beat_data_q[gnt][0], s_r_data_o);
      check_bit("slave r last", beat_last_q[gnt][0], s_r_last_o);
    end
    if (xfer) begin
      // last beat retires the burst for its id
      if (beat_last_q[gnt][0]) begin
        id_cnt[beat_id_q[gnt][0]]--;
      end
      void'(beat_data_q[gnt].pop_front());
      void'(beat_id_q[gnt].pop_front());
      void'(beat_last_q[gnt].pop_front());
      r_hold[gnt] = 1'b0;
      rr_ptr      = demux_pkg::port_sel_t'((int'(gnt) + 1) % `NUM_PORTS);
      r_lock      = 1'b0;
    end else if (exp_valid) begin
      r_lock     = 1'b1;
      r_lock_idx = gnt;
    end
  endtask

  function automatic logic all_drained();
    logic idle;
    idle = (ar_sent == NUM_ARS) && !ar_pending;
    for (int p = 0; p < `NUM_PORTS; p++) begin
      idle &= (beat_data_q[p].size() == 0);
    end
    for (int i = 0; i < NUM_IDS; i++) begin
      idle &= (id_cnt[i] == 0);
    end
    return idle;
  endfunction

  // --------------------------------------------------
  // stimulus, driven on the rising edge
  // --------------------------------------------------

  // ars 100 to 199 map port from id and drain r slowly,
  // so counters climb to the full stall
  task automatic drive_inputs();
    demux_pkg::axi_id_t   id;
    demux_pkg::port_sel_t sel;
    logic                 slow_phase;
    slow_phase = (ar_sent >= 100) && (ar_sent < 200);
    if (!ar_pending && ar_sent < NUM_ARS && take_bits(2) != 0) begin
      id  = demux_pkg::axi_id_t'(take_bits(`ID_BITS));
      sel = demux_pkg::port_sel_t'(take_bits($bits(demux_pkg::port_sel_t)));
      if (slow_phase) begin
        sel = demux_pkg::port_sel_t'(id);
      end
      s_ar_id_i   <= id;
      s_ar_sel_i  <= sel;
      s_ar_addr_i <= demux_pkg::addr_t'(take_bits(`ADDR_BITS));
      ar_pending  = 1'b1;
      ar_sent++;
    end
    s_ar_valid_i <= ar_pending;
    for (int p = 0; p < `NUM_PORTS; p++) begin
      m_ar_ready_i[p] <= (take_bits(2) != 0);
      // random gap before the next beat, then held until taken
      if (!r_hold[p] && beat_data_q[p].size() > 0) begin
        r_hold[p] = (take_bits(2) != 0);
      end
      m_r_valid_i[p] <= r_hold[p];
      if (r_hold[p]) begin
        m_r_id_i[p]   <= beat_id_q[p][0];
        m_r_data_i[p] <= beat_data_q[p][0];
        m_r_last_i[p] <= beat_last_q[p][0];
      end
    end
    s_r_ready_i <= slow_phase ? (take_bits(3) == 0) : (take_bits(2) != 0);
  endtask

  // --------------------------------------------------
  // main sequence
  // --------------------------------------------------
  initial begin
    lfsr_q       = 16'd34;
    rst_n_i      = 1'b0;
    s_ar_valid_i = 1'b0;
    s_ar_id_i    = '0;
    s_ar_addr_i  = '0;
    s_ar_sel_i   = '0;
    m_ar_ready_i = '0;
    m_r_valid_i  = '0;
    m_r_id_i     = '0;
    m_r_data_i   = '0;
    m_r_last_i   = '0;
    s_r_ready_i  = 1'b0;
    for (int i = 0; i < NUM_IDS; i++) begin
      id_cnt[i] = 0;
      id_tgt[i] = '0;
    end
    ar_pending = 1'b0;
    ar_locked  = 1'b0;
    ar_sent    = 0;
    rr_ptr     = '0;
    r_lock     = 1'b0;
    r_lock_idx = '0;
    r_hold     = '0;
    cycles     = 0;
    run_done   = 1'b0;
    repeat (4) begin
      @(negedge clk_i);
      check_idle_outputs();
    end
    @(posedge clk_i);
    rst_n_i <= 1'b1;
    while (!run_done) begin
      @(negedge clk_i);
      cycles++;
      // inputs still idle in the first cycle out of reset
      if (cycles == 1) begin
        check_idle_outputs();
      end
      if (cycles > MAX_CYCLES) begin
        $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
        fail_run();
      end
      check_ar_side();
      check_r_side();
      run_done = all_drained();
      if (!run_done) begin
        @(posedge clk_i);
        drive_inputs();
      end
    end
    $display("All checks passed");
    $finish;
  end

endmodule

`default_nettype wire

//--- flist.f
+incdir+common
common/demux_pkg.sv
ar_route/id_flight_slot.sv
ar_route/ar_route_ctrl.sv
verilog/r_rr_mux.sv
verilog/axi_rd_demux.sv
testbench/axi_rd_demux_sva.sv
testbench/tb_axi_rd_demux.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the read demux testbench with verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f flist.f \
  --top-module tb_axi_rd_demux -Mdir obj_dir -o tb_sim \
  && ./obj_dir/tb_sim \
  || { echo "simulation failed"; exit 1; }
